// ==== fetchPredictor.f ====
+incdir+include
source/fetchPkg.sv
source/pcGenerator.sv
source/branchTargetBuffer.sv
source/branchSelector.sv
source/fetchPredictor.sv
tests/fetchPredictorTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f fetchPredictor.f \
    --top-module fetchPredictorTb -o simv || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/simv)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1

// ==== tests/fetchPredictorTb.sv ====
// Outputs are sampled at the falling edge; all repair addresses are kept word aligned
`timescale 1ns/1ps
`include "fetchPredict_config.svh"

module fetchPredictorTb;

    logic                 clk;
    logic                 rst;
    logic                 stall;
    logic                 repairValid;
    fetchPkg::repairReqT  repairReq;
    logic                 fetchValid;
    fetchPkg::fetchGroupT fetchGroup;
    fetchPkg::nextFetchT  nextFetch;

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------
    bit               mBtbValid  [`FETCH_LANES][`BTB_ENTRIES];
    fetchPkg::btbTagT mBtbTag    [`FETCH_LANES][`BTB_ENTRIES];
    logic [29:0]      mBtbTarget [`FETCH_LANES][`BTB_ENTRIES];  // Word target
    fetchPkg::vAddrT  mPc;
    fetchPkg::vAddrT  mSaved;       // Target held over the slot-only group
    logic             mDelaySlot;
    logic             mValid;
    logic             curStall;     // Inputs the DUT samples at the next edge
    logic             curRepValid;
    fetchPkg::repairReqT curRep;
    fetchPkg::repairReqT noRep;
    logic [31:0]      rngState;
    int               errors;
    int               errorsAtStart;
    int               testsRun;
    int               testsFailed;

    fetchPredictor dut (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall),
        .repairValid_i (repairValid),
        .repair_i      (repairReq),
        .fetchValid_o  (fetchValid),
        .fetchGroup_o  (fetchGroup),
        .nextFetch_o   (nextFetch)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;   // 40 ns period

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic fetchPkg::repairReqT makeRepair(input fetchPkg::vAddrT pc,
                                                       input logic taken,
                                                       input fetchPkg::vAddrT dest);
        fetchPkg::repairReqT rq;
        rq.branchPc = pc;
        rq.taken    = taken;
        rq.dest     = dest;
        return rq;
    endfunction

    // Lanes at or above the entry word
    function automatic fetchPkg::laneMaskT entryMask(input fetchPkg::vAddrT addr);
        fetchPkg::laneMaskT m;
        for (int i = 0; i < `FETCH_LANES; i++) begin
            m[i] = (i >= int'(addr[3:2]));
        end
        return m;
    endfunction

    function automatic fetchPkg::fetchGroupT modelGroup();
        fetchPkg::fetchGroupT g;
        g.pc            = mPc;
        g.delaySlotOnly = mDelaySlot;
        g.mask          = mDelaySlot ? 4'b0001 : entryMask(mPc);   // Slot sits in word 0
        return g;
    endfunction

    function automatic fetchPkg::nextFetchT modelNext(input fetchPkg::fetchGroupT g);
        fetchPkg::nextFetchT n;
        int k;
        int idx;
        k   = -1;
        idx = int'(g.pc[11:4]);
        if (!g.delaySlotOnly) begin
            for (int i = `FETCH_LANES - 1; i >= 0; i--) begin
                if (g.mask[i] && mBtbValid[i][idx] && mBtbTag[i][idx] == g.pc[19:12]) begin
                    k = i;   // Lowest lane ends up here
                end
            end
        end
        n.validTake     = (k >= 0);
        n.needDelaySlot = (k == `FETCH_LANES - 1);
        if (k >= 0) begin
            n.validDest = {mBtbTarget[k][idx], 2'b00};
            for (int i = 0; i < `FETCH_LANES; i++) begin
                n.usedMask[i] = g.mask[i] && (i <= k + 1);   // Branch plus its slot
            end
        end else begin
            n.validDest = (g.pc & ~32'hF) + 32'd16;
            n.usedMask  = g.mask;
        end
        return n;
    endfunction

    // Applies the inputs the DUT just sampled
    task automatic modelEdge();
        fetchPkg::nextFetchT n;
        int bank;
        int idx;
        n    = modelNext(modelGroup());   // Lookup before any write
        bank = int'(curRep.branchPc[3:2]);
        idx  = int'(curRep.branchPc[11:4]);
        if (curRepValid) begin
            mBtbValid[bank][idx]  = curRep.taken;
            mBtbTag[bank][idx]    = curRep.branchPc[19:12];
            mBtbTarget[bank][idx] = curRep.dest[31:2];
            mPc        = curRep.taken ? curRep.dest : curRep.branchPc + 32'd8;
            mDelaySlot = 1'b0;
        end else if (mValid && !curStall) begin
            if (mDelaySlot) begin
                mPc        = mSaved;
                mDelaySlot = 1'b0;
            end else if (n.needDelaySlot) begin
                mSaved     = n.validDest;
                mPc        = (mPc & ~32'hF) + 32'd16;
                mDelaySlot = 1'b1;
            end else begin
                mPc = n.validDest;
            end
        end
        mValid = 1'b1;
    endtask

    task automatic failCheck(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic compareModel();
        fetchPkg::fetchGroupT g;
        fetchPkg::nextFetchT  n;
        g = modelGroup();
        n = modelNext(g);
        if (fetchValid !== mValid)
            failCheck($sformatf("fetchValid %b, model %b", fetchValid, mValid));
        if (fetchGroup !== g) failCheck($sformatf("fetchGroup %h, model %h", fetchGroup, g));
        if (nextFetch !== n) failCheck($sformatf("nextFetch %h, model %h", nextFetch, n));
    endtask

    // Model edge and drive, then check mid-cycle
    task automatic runCycle(input logic st, input logic rv, input fetchPkg::repairReqT rq);
        @(posedge clk);
        modelEdge();
        stall       <= st;
        repairValid <= rv;
        repairReq   <= rq;
        curStall    = st;
        curRepValid = rv;
        curRep      = rq;
        @(negedge clk);
        compareModel();
    endtask

    // Not-taken repair just before addr lands on the second edge
    task automatic redirectTo(input fetchPkg::vAddrT addr);
        runCycle(1'b0, 1'b1, makeRepair(addr - 32'd8, 1'b0, 32'd0));
        runCycle(1'b0, 1'b0, noRep);
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errors > errorsAtStart) begin
            testsFailed++;
            $display("Test %s: failed", name);
        end else begin
            $display("Test %s: passed", name);
        end
        errorsAtStart = errors;
    endtask

    initial begin
        fetchPkg::vAddrT      base;
        fetchPkg::vAddrT      target;
        fetchPkg::vAddrT      prevPc;
        fetchPkg::fetchGroupT held;
        fetchPkg::repairReqT  rq;
        logic [31:0]          r;
        logic [31:0]          r2;
        int                   cnt;
        int                   takenSeen;
        rst = 1'b0;
        stall = 1'b0;
        repairValid = 1'b0;
        repairReq = '0;
        noRep = '0;
        curStall = 1'b0;
        curRepValid = 1'b0;
        curRep = '0;
        rngState = 32'h9c8b655c;
        errors = 0;
        errorsAtStart = 0;
        testsRun = 0;
        testsFailed = 0;
        takenSeen = 0;
        mPc = `RESET_PC;
        mSaved = '0;
        mDelaySlot = 1'b0;
        mValid = 1'b0;
        foreach (mBtbValid[b, e]) mBtbValid[b][e] = 1'b0;

        // ----------------------------------------
        // Reset and first group
        // ----------------------------------------
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 4) rst <= 1'b1;
            @(negedge clk);
            if (fetchValid !== 1'b0) failCheck("fetchValid_o high during reset");
        end
        compareModel();
        cnt = 0;
        while (fetchValid !== 1'b1 && cnt < 8) begin
            runCycle(1'b0, 1'b0, noRep);
            cnt++;
        end
        if (fetchValid !== 1'b1) begin
            $display("Timeout: fetchValid_o never went high after reset");
            errors++;
        end
        if (fetchGroup.pc != `RESET_PC || fetchGroup.mask != 4'hF || fetchGroup.delaySlotOnly)
            failCheck($sformatf("first group %h is not the reset group", fetchGroup));
        finishTest("reset");

        // Empty table, then a two-cycle stall
        for (int i = 0; i < 4; i++) begin
            prevPc = fetchGroup.pc;
            runCycle(1'b0, 1'b0, noRep);
            if (fetchGroup.pc != prevPc + 32'd16) failCheck("pc did not step by 16");
            if (nextFetch.validTake) failCheck("empty table predicted a branch");
            if (nextFetch.usedMask != fetchGroup.mask) failCheck("usedMask differs from mask");
        end
        runCycle(1'b1, 1'b0, noRep);
        held = fetchGroup;
        runCycle(1'b1, 1'b0, noRep);
        if (fetchGroup != held) failCheck("stall did not hold the group");
        runCycle(1'b0, 1'b0, noRep);
        if (fetchGroup != held) failCheck("second stall cycle did not hold the group");
        runCycle(1'b0, 1'b0, noRep);
        if (fetchGroup.pc != held.pc + 32'd16) failCheck("fetch did not resume after stall");
        finishTest("empty table");

        // ----------------------------------------
        // Taken branches in lanes 0 to 2
        // ----------------------------------------
        for (int k = 0; k < 3; k++) begin
            base   = 32'h0001_2000 + k * 32'h40;
            target = 32'h0003_0000 + k * 32'h104;    // Target word is lane k
            runCycle(1'b0, 1'b1, makeRepair(base + 4 * k, 1'b1, target));
            redirectTo(base);
            if (fetchGroup.pc != base || !nextFetch.validTake || nextFetch.validDest != target)
                failCheck($sformatf("branch in lane %0d not predicted", k));
            if (nextFetch.usedMask != 4'((1 << (k + 2)) - 1))
                failCheck($sformatf("usedMask %b wrong for lane %0d", nextFetch.usedMask, k));
            runCycle(1'b0, 1'b0, noRep);
            if (fetchGroup.pc != target || fetchGroup.mask != entryMask(target))
                failCheck($sformatf("group after lane %0d branch is %h", k, fetchGroup));
        end
        finishTest("taken lanes 0-2");

        // Lane 3 branch with a decoy entry in the slot block
        base   = 32'h0001_4000;
        target = 32'h0003_5008;
        runCycle(1'b0, 1'b1, makeRepair(base + 32'd16, 1'b1, 32'h0003_6000));
        runCycle(1'b0, 1'b1, makeRepair(base + 32'd12, 1'b1, target));
        redirectTo(base);
        if (!nextFetch.validTake || !nextFetch.needDelaySlot || nextFetch.usedMask != 4'hF)
            failCheck("lane 3 branch did not request its delay slot");
        runCycle(1'b0, 1'b0, noRep);
        if (fetchGroup.pc != base + 32'd16 || fetchGroup.mask != 4'b0001
                || !fetchGroup.delaySlotOnly)
            failCheck($sformatf("slot-only group wrong: %h", fetchGroup));
        if (nextFetch.validTake) failCheck("delay-slot-only group predicted a branch");
        runCycle(1'b0, 1'b0, noRep);
        if (fetchGroup.pc != target || fetchGroup.mask != 4'b1100 || fetchGroup.delaySlotOnly)
            failCheck($sformatf("group after delay slot is %h", fetchGroup));
        finishTest("taken lane 3");

        // ----------------------------------------
        // Clearing, aliasing, repair under stall
        // ----------------------------------------
        base = 32'h0001_2000;
        runCycle(1'b0, 1'b1, makeRepair(base, 1'b0, 32'd0));
        runCycle(1'b0, 1'b0, noRep);
        if (fetchGroup.pc != base + 32'd8) failCheck("not-taken repair missed branchPc + 8");
        redirectTo(base);
        if (nextFetch.validTake) failCheck("cleared entry still predicts");
        runCycle(1'b0, 1'b0, noRep);
        if (fetchGroup.pc != base + 32'd16) failCheck("cleared block did not go sequential");
        redirectTo(32'h0001_3040);   // Same index as a lane 1 entry but another tag
        if (nextFetch.validTake) failCheck("different tag hit in the BTB");
        runCycle(1'b1, 1'b0, noRep);
        runCycle(1'b1, 1'b1, makeRepair(32'h0005_0000, 1'b1, 32'h0006_0020));
        runCycle(1'b1, 1'b0, noRep);
        if (fetchGroup.pc != 32'h0006_0020) failCheck("repair lost while stalled");
        runCycle(1'b1, 1'b0, noRep);
        if (fetchGroup.pc != 32'h0006_0020) failCheck("stall after repair did not hold");
        runCycle(1'b0, 1'b0, noRep);
        finishTest("clear and alias");

        // Random mix with branches and targets kept near fetch
        for (int c = 0; c < 2000; c++) begin
            r  = nextRand();
            r2 = nextRand();
            rq = makeRepair({mPc[31:4] + 28'(r[6:5]), r[8:7], 2'b00}, r2[1:0] != 2'b00,
                            {mPc[31:8], r2[7:2], 2'b00});
            runCycle(r[1:0] == 2'b00, r[4:2] == 3'b000, rq);
            if (nextFetch.validTake) takenSeen++;
        end
        if (takenSeen == 0) failCheck("random run never produced a taken prediction");
        finishTest("random");

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== source/fetchPredictor.sv ====
// Prediction is valid in the same cycle as its group; no back-pressure besides stall_i
`timescale 1ns/1ps

module fetchPredictor (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall_i,
    input  logic                 repairValid_i,
    input  fetchPkg::repairReqT  repair_i,
    output logic                 fetchValid_o,
    output fetchPkg::fetchGroupT fetchGroup_o,
    output fetchPkg::nextFetchT  nextFetch_o
);

    fetchPkg::fetchGroupT fetchGroup;   // Fetch register view
    fetchPkg::lanePredT   lanePred;     // Per-lane BTB result
    fetchPkg::nextFetchT  nextFetch;    // Selector decision, loops back

    // Producer
    pcGenerator uPcGen (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall_i),
        .repairValid_i (repairValid_i),
        .repair_i      (repair_i),
        .nextFetch_i   (nextFetch),
        .fetchGroup_o  (fetchGroup),
        .fetchValid_o  (fetchValid_o)
    );

    branchTargetBuffer uBtb (
        .clk           (clk),
        .rst           (rst),
        .fetchGroup_i  (fetchGroup),
        .repairValid_i (repairValid_i),
        .repair_i      (repair_i),
        .lanePred_o    (lanePred)
    );

    branchSelector uSel (.fetchGroup_i(fetchGroup), .lanePred_i(lanePred), .nextFetch_o(nextFetch));

    assign fetchGroup_o = fetchGroup;
    assign nextFetch_o  = nextFetch;

endmodule

// ==== source/branchSelector.sv ====
// Purely combinational; predictions of a delay-slot-only group are ignored by design
`timescale 1ns/1ps
`include "fetchPredict_config.svh"

module branchSelector (
    input  fetchPkg::fetchGroupT fetchGroup_i,
    input  fetchPkg::lanePredT   lanePred_i,
    output fetchPkg::nextFetchT  nextFetch_o
);

    localparam int laneBits = $clog2(`FETCH_LANES);

    fetchPkg::laneMaskT  enabled;    // Lanes allowed to predict
    fetchPkg::laneMaskT  hits;
    fetchPkg::laneMaskT  keepMask;   // Lanes up to the delay slot
    logic [laneBits-1:0] hitLane;
    logic                anyHit;
    fetchPkg::vAddrT     nextBlock;

    // ----------------------------------------
    // First taken branch
    // ----------------------------------------
    assign enabled   = fetchGroup_i.delaySlotOnly ? '0 : fetchGroup_i.mask;
    assign hits      = enabled & lanePred_i.take;
    assign anyHit    = |hits;
    assign nextBlock = {fetchGroup_i.pc[31:4] + 28'd1, 4'b0000};

    // Scan high to low so lowest lane wins
    always_comb begin
        hitLane = '0;
        for (int i = `FETCH_LANES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                hitLane = laneBits'(i);
            end
        end
    end

    // Keep branch lane plus its slot
    always_comb begin
        for (int i = 0; i < `FETCH_LANES; i++) begin
            keepMask[i] = (i <= int'(hitLane) + 1);
        end
    end

    // ----------------------------------------
    // Next-address decision
    // ----------------------------------------
    always_comb begin
        nextFetch_o.validTake = anyHit;
        if (anyHit) begin
            nextFetch_o.validDest     = lanePred_i.dest[hitLane];
            nextFetch_o.needDelaySlot = (hitLane == laneBits'(`FETCH_LANES - 1));
            nextFetch_o.usedMask      = fetchGroup_i.mask & keepMask;
        end else begin
            nextFetch_o.validDest     = nextBlock;             // Fall through
            nextFetch_o.needDelaySlot = 1'b0;
            nextFetch_o.usedMask      = fetchGroup_i.mask;
        end
    end

endmodule

// ==== source/branchTargetBuffer.sv ====
// Lookup is combinational and sees the old entry on a repair cycle; lane address bits 3:2 pick the bank
`timescale 1ns/1ps
`include "fetchPredict_config.svh"

module branchTargetBuffer (
    input  logic                 clk,
    input  logic                 rst,
    input  fetchPkg::fetchGroupT fetchGroup_i,
    input  logic                 repairValid_i,
    input  fetchPkg::repairReqT  repair_i,
    output fetchPkg::lanePredT   lanePred_o
);

    localparam int laneBits  = $clog2(`FETCH_LANES);
    localparam int indexBits = $clog2(`BTB_ENTRIES);
    localparam int tagLsb    = indexBits + 4;        // Tag sits just above the index

    fetchPkg::btbIndexT repIdx;
    fetchPkg::btbTagT   repTag;

    // Write side, shared by all banks
    assign repIdx = repair_i.branchPc[4 +: indexBits];
    assign repTag = repair_i.branchPc[tagLsb +: `BTB_TAG_BITS];

    // ----------------------------------------
    // One bank per lane
    // ----------------------------------------
    for (genvar lane = 0; lane < `FETCH_LANES; lane++) begin : gBank
        logic [31:2]          targetMem [`BTB_ENTRIES];   // Word target
        fetchPkg::btbTagT     tagMem    [`BTB_ENTRIES];
        logic [`BTB_ENTRIES-1:0] validBits;
        fetchPkg::vAddrT      laneAddr;
        fetchPkg::btbIndexT   lookIdx;
        fetchPkg::btbTagT     lookTag;
        logic                 hit;
        logic                 wen;

        // Word address of this lane within the block
        assign laneAddr = {fetchGroup_i.pc[31:4], laneBits'(lane), 2'b00};
        assign lookIdx  = laneAddr[4 +: indexBits];
        assign lookTag  = laneAddr[tagLsb +: `BTB_TAG_BITS];
        assign hit      = validBits[lookIdx] && (tagMem[lookIdx] == lookTag);

        assign lanePred_o.take[lane] = hit;
        assign lanePred_o.dest[lane] = hit ? {targetMem[lookIdx], 2'b00}
                                           : laneAddr + 32'd8;   // Past own delay slot

        // Only the bank of the branch's own word is written
        assign wen = repairValid_i && (repair_i.branchPc[3:2] == laneBits'(lane));

        always_ff @(posedge clk) begin
            if (!rst) begin
                validBits <= '0;
            end else if (wen) begin
                validBits[repIdx] <= repair_i.taken;   // Not-taken clears
            end
        end

        // Payload arrays
        always_ff @(posedge clk) begin
            if (wen) begin
                targetMem[repIdx] <= repair_i.dest[31:2];
                tagMem[repIdx]    <= repTag;
            end
        end
    end

    // Execute stage must present a clean request with the strobe
    repairKnown: assert property (@(posedge clk) disable iff (!rst)
        repairValid_i |-> !$isunknown(repair_i));

endmodule

// ==== source/pcGenerator.sv ====
// Repair dest must be word aligned; stall has no effect while a repair strobe is high
`timescale 1ns/1ps
`include "fetchPredict_config.svh"

module pcGenerator (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall_i,
    input  logic                 repairValid_i,
    input  fetchPkg::repairReqT  repair_i,
    input  fetchPkg::nextFetchT  nextFetch_i,
    output fetchPkg::fetchGroupT fetchGroup_o,
    output logic                 fetchValid_o
);

    fetchPkg::vAddrT      pcQ;         // Current fetch address
    fetchPkg::vAddrT      savedDestQ;  // Target parked during delay-slot fetch
    fetchPkg::fetchStateE stateQ;
    logic                 validQ;
    fetchPkg::vAddrT      nextBlock;
    fetchPkg::vAddrT      repairDest;
    logic                 advance;
    logic                 parkTarget;

    // ----------------------------------------
    // Next-address candidates
    // ----------------------------------------
    assign nextBlock  = {pcQ[31:4] + 28'd1, 4'b0000};   // Sequential block
    assign repairDest = repair_i.taken ? repair_i.dest
                                       : repair_i.branchPc + 32'd8;  // Skip the delay slot
    assign advance    = validQ && !stall_i;
    // Branch in last lane and no repair competing
    assign parkTarget = !repairValid_i && advance && (stateQ == fetchPkg::NORMAL)
                        && nextFetch_i.needDelaySlot;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pcQ    <= `RESET_PC;
            stateQ <= fetchPkg::NORMAL;
            validQ <= 1'b0;
        end else begin
            validQ <= 1'b1;                  // First group shows after reset
            if (repairValid_i) begin         // Repair beats stall and state
                pcQ    <= repairDest;
                stateQ <= fetchPkg::NORMAL;
            end else if (advance) begin
                if (stateQ == fetchPkg::DELAYSLOT) begin
                    pcQ    <= savedDestQ;    // Resume at target after the slot
                    stateQ <= fetchPkg::NORMAL;
                end else if (nextFetch_i.needDelaySlot) begin
                    pcQ    <= nextBlock;     // Slot-only block
                    stateQ <= fetchPkg::DELAYSLOT;
                end else begin
                    pcQ    <= nextFetch_i.validDest;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (parkTarget) begin
            savedDestQ <= nextFetch_i.validDest;
        end
    end

    // ----------------------------------------
    // Group outputs
    // ----------------------------------------
    assign fetchGroup_o.pc            = pcQ;
    assign fetchGroup_o.delaySlotOnly = (stateQ == fetchPkg::DELAYSLOT);
    assign fetchGroup_o.mask          = (stateQ == fetchPkg::DELAYSLOT)
                                        ? fetchPkg::laneMaskT'(1)          // Lane 0 only
                                        : {`FETCH_LANES{1'b1}} << pcQ[3:2]; // Lanes from entry word up
    assign fetchValid_o               = validQ;

    // Redirects from selector and repair must keep fetch word aligned
    pcAligned: assert property (@(posedge clk) disable iff (!rst)
        fetchValid_o |-> fetchGroup_o.pc[1:0] == 2'b00);

endmodule

// ==== source/fetchPkg.sv ====
// Widths follow fetchPredict_config.svh; struct field order is fixed and matters to packing
`include "fetchPredict_config.svh"

package fetchPkg;

    typedef logic [31:0]                       vAddrT;     // Virtual address
    typedef logic [`FETCH_LANES-1:0]           laneMaskT;  // Bit i is word i of block
    typedef logic [$clog2(`BTB_ENTRIES)-1:0]   btbIndexT;  // Bank row
    typedef logic [`BTB_TAG_BITS-1:0]          btbTagT;    // Stored tag

    typedef enum logic {NORMAL, DELAYSLOT} fetchStateE;

    // Resolved branch from execute
    typedef struct packed {
        vAddrT branchPc;
        logic  taken;      // Low clears the entry
        vAddrT dest;
    } repairReqT;

    typedef struct packed {
        vAddrT    pc;
        laneMaskT mask;
        logic     delaySlotOnly;  // Group carries just the pending delay slot
    } fetchGroupT;

    typedef struct packed {
        laneMaskT                    take;
        vAddrT [`FETCH_LANES-1:0]    dest;  // Per-lane target or fall-through
    } lanePredT;

    typedef struct packed {
        logic     validTake;
        vAddrT    validDest;
        logic     needDelaySlot;  // Branch in last lane, slot is in next block
        laneMaskT usedMask;
    } nextFetchT;

endpackage

// ==== include/fetchPredict_config.svh ====
// Assumes four 32-bit lanes per 16-byte block; index and tag must fit in the address bits above 3
`ifndef FETCH_PREDICT_CONFIG_SVH
`define FETCH_PREDICT_CONFIG_SVH

// ----------------------------------------
// Fetch geometry
// ----------------------------------------
`define FETCH_LANES   4              // Words per fetch block

// ----------------------------------------
// BTB sizing
// ----------------------------------------
`define BTB_ENTRIES   256            // Entries per bank, index from bits 11:4
`define BTB_TAG_BITS  8              // Stored tag, taken from bits 19:12

// Boot vector in kseg1
`define RESET_PC      32'hBFC00000

`endif
